//--- include/pec_params.svh
`ifndef PEC_PARAMS_SVH
`define PEC_PARAMS_SVH

// Activation and weight value width
`define PEC_DATA_WIDTH 8
// Channels per activation or weight vector
`define PEC_CHANNEL_DEPTH 4
// Taps per kernel row, also number of rows
`define PEC_KERNEL 3
// One partial-sum entry per row of a block
`define PEC_PSUM_DEPTH 4
// 2*8 product plus channel and tap growth
`define PEC_PSUM_WIDTH 20

`endif

//--- src/pec_ctrl_pkg.sv
`default_nettype none

// ========================================================================
// Control-side types of the PE cluster
// ========================================================================
package pec_ctrl_pkg;

    // Markers carried with every activation
    typedef struct packed {
        logic frtRow;   // First activation of a row, read psum
        logic lstRow;   // Last activation of a row, write psum
        logic lstBlk;   // Last of block, reload weights after
    } rowMark_t;

    // Controller FSM
    typedef enum logic [2:0] {IDLE, CFGWEI, CFGACT, RUN, WAITGET} pecState_t;

endpackage

`default_nettype wire

//--- src/pec_data_pkg.sv
`default_nettype none

`include "pec_params.svh"

// ========================================================================
// Datapath types of the PE cluster
// ========================================================================
package pec_data_pkg;

    typedef logic [`PEC_CHANNEL_DEPTH-1:0][`PEC_DATA_WIDTH-1:0] actVec_t;  // Also weights
    typedef logic [`PEC_CHANNEL_DEPTH-1:0] flagVec_t;    // Nonzero flag per channel
    typedef logic [`PEC_PSUM_WIDTH-1:0] psum_t;          // Two's complement sum
    typedef logic [$clog2(`PEC_PSUM_DEPTH)-1:0] psumAddr_t;

    // Activation as it travels between elements
    typedef struct packed {
        actVec_t               act;
        flagVec_t              flags;
        pec_ctrl_pkg::rowMark_t mark;
    } actWord_t;

    // One kernel row, index is the tap
    typedef struct packed {
        actVec_t  [`PEC_KERNEL-1:0] wei;
        flagVec_t [`PEC_KERNEL-1:0] flg;
    } rowWeights_t;

    typedef rowWeights_t [`PEC_KERNEL-1:0] kernel_t;   // Index is the kernel row
    typedef psum_t [`PEC_KERNEL-1:0] psumWord_t;       // One sum per tap

endpackage

`default_nettype wire

//--- src/act_stage.sv
`default_nettype none

// Input side: held register from the previous element, forward copy to the next one
module act_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   actReq,
    output logic                   actAck,
    input  pec_data_pkg::actWord_t actIn,
    output logic                   actValid,
    output pec_data_pkg::actWord_t heldAct,
    input  logic                   actTake,
    output logic                   fwdBusy,
    output logic                   nxtReq,
    input  logic                   nxtAck,
    output pec_data_pkg::actWord_t nxtAct
);

    logic capture;     // Accept edge of the inbound link

    // Forward copy in flight until the receiver drops ack
    assign fwdBusy = nxtReq | nxtAck;
    // Empty stage, previous handshake closed, nothing stuck downstream
    assign capture = actReq && !actAck && !actValid && !fwdBusy;

    // ========================================================================
    // Inbound side
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            actAck   <= 1'b0;
            actValid <= 1'b0;
        end else begin
            if (capture)
                actAck <= 1'b1;           // High the cycle after capture
            else if (actAck && !actReq)
                actAck <= 1'b0;           // Close four-phase
            if (capture)
                actValid <= 1'b1;
            else if (actTake)
                actValid <= 1'b0;         // Controller has it
        end
    end

    always_ff @(posedge clk) begin
        if (capture)
            heldAct <= actIn;
    end

    // ========================================================================
    // Forward side
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            nxtReq <= 1'b0;
        else if (actTake)
            nxtReq <= 1'b1;               // Data already in nxtAct
        else if (nxtReq && nxtAck)
            nxtReq <= 1'b0;
    end

    // Stable while req or ack is up, take is blocked by fwdBusy
    always_ff @(posedge clk) begin
        if (actTake)
            nxtAct <= heldAct;
    end

endmodule

`default_nettype wire

//--- src/mac_row.sv
`default_nettype none

`include "pec_params.svh"

// One kernel row: three sparse MACs over the same activation
module mac_row (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      macStart,
    input  pec_data_pkg::actVec_t     act,
    input  pec_data_pkg::flagVec_t    actFlags,
    input  pec_data_pkg::rowWeights_t weights,
    output logic                      done,
    output pec_data_pkg::psumWord_t   rowPsum
);

    localparam int CH_W   = $clog2(`PEC_CHANNEL_DEPTH);
    localparam int PROD_W = 2 * `PEC_DATA_WIDTH;

    pec_data_pkg::actVec_t   actReg;     // Activation copy, stage may refill meanwhile
    logic                    busy;
    logic [`PEC_KERNEL-1:0]  tapIdle;    // No channel left for that tap

    // Lowest pending channel
    function automatic logic [CH_W-1:0] lowestSet(input pec_data_pkg::flagVec_t m);
        logic [CH_W-1:0] idx;
        idx = '0;
        for (int i = `PEC_CHANNEL_DEPTH - 1; i >= 0; i--) begin
            if (m[i])
                idx = CH_W'(i);
        end
        return idx;
    endfunction

    always_ff @(posedge clk) begin
        if (macStart)
            actReg <= act;
    end

    // Done once the busiest tap runs dry, one cycle after its last step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (macStart) begin
            busy <= 1'b1;
            done <= 1'b0;
        end else if (busy && (&tapIdle)) begin
            busy <= 1'b0;
            done <= 1'b1;       // Held until next start
        end
    end

    // ========================================================================
    // Per-tap MAC, one channel with both flags set per cycle
    // ========================================================================
    for (genvar t = 0; t < `PEC_KERNEL; t++) begin : genTap
        pec_data_pkg::flagVec_t     pend;   // Channels still to add
        pec_data_pkg::psum_t        acc;
        logic [CH_W-1:0]            ch;
        logic signed [PROD_W-1:0]   prod;

        assign ch         = lowestSet(pend);
        assign prod       = $signed(actReg[ch]) * $signed(weights.wei[t][ch]);
        assign tapIdle[t] = (pend == '0);
        assign rowPsum[t] = acc;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n)
                pend <= '0;
            else if (macStart)
                pend <= actFlags & weights.flg[t];   // Zero channels skipped
            else if (!tapIdle[t])
                pend <= pend & (pend - 1'b1);        // Drop lowest bit
        end

        always_ff @(posedge clk) begin
            if (macStart)
                acc <= '0;
            else if (!tapIdle[t])
                acc <= acc + `PEC_PSUM_WIDTH'(prod);  // Sign-extended product
        end
    end

endmodule

`default_nettype wire

//--- src/pec_ctrl.sv
`default_nettype none

`include "pec_params.svh"

// Cluster controller: weight load, MAC start, row and block events
module pec_ctrl (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      weiReq,
    output logic                                      weiAck,
    input  pec_data_pkg::kernel_t                     kernelIn,
    output pec_data_pkg::kernel_t                     kernelOut,
    input  logic                                      actValid,
    input  pec_ctrl_pkg::rowMark_t                    heldMark,
    output logic                                      actTake,
    input  logic                                      fwdBusy,
    input  logic                                      resBusy,
    output logic                                      macStart,
    input  logic [`PEC_KERNEL-1:0]                    rowDone,
    input  pec_data_pkg::psumWord_t [`PEC_KERNEL-1:0] rowPsum,
    input  pec_data_pkg::psumWord_t                   rdData,
    output logic                                      rdEn,
    output logic                                      wrEn,
    output pec_data_pkg::psumWord_t                   wrData,
    output logic                                      blkEnd
);

    pec_ctrl_pkg::pecState_t state, nextState;
    pec_data_pkg::kernel_t   kernelReg;
    pec_data_pkg::psumWord_t accReg;      // Running row sum
    pec_data_pkg::psumWord_t sumWord;
    pec_ctrl_pkg::rowMark_t  markReg;     // Markers of the activation in flight
    logic weiCap, weiDone, takeOk, runDone;

    assign weiCap  = (state == pec_ctrl_pkg::CFGWEI) && weiReq && !weiAck;
    assign weiDone = (state == pec_ctrl_pkg::CFGWEI) && weiAck && !weiReq;
    assign takeOk  = (state == pec_ctrl_pkg::CFGACT) && actValid && !fwdBusy && !resBusy;
    assign runDone = (state == pec_ctrl_pkg::RUN) && (&rowDone);

    // ========================================================================
    // FSM
    // ========================================================================
    always_comb begin
        nextState = state;
        case (state)
            pec_ctrl_pkg::IDLE:    nextState = pec_ctrl_pkg::CFGWEI;
            pec_ctrl_pkg::CFGWEI:  if (weiDone) nextState = pec_ctrl_pkg::CFGACT;
            pec_ctrl_pkg::CFGACT:  if (takeOk) nextState = pec_ctrl_pkg::RUN;
            pec_ctrl_pkg::RUN:     if (runDone) nextState = pec_ctrl_pkg::WAITGET;
            // Block end means a fresh weight set
            pec_ctrl_pkg::WAITGET: nextState = markReg.lstBlk ? pec_ctrl_pkg::IDLE
                                                              : pec_ctrl_pkg::CFGACT;
            default:               nextState = pec_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= pec_ctrl_pkg::IDLE;
            weiAck  <= 1'b0;
            markReg <= '0;
        end else begin
            state <= nextState;
            if (weiCap)
                weiAck <= 1'b1;
            else if (weiAck && !weiReq)
                weiAck <= 1'b0;      // Handshake complete
            if (takeOk)
                markReg <= heldMark;
        end
    end

    always_ff @(posedge clk) begin
        if (weiCap)
            kernelReg <= kernelIn;   // Stable for the whole block
        if (runDone)
            accReg <= sumWord;
    end

    // Base is memory on first of row, else running sum; then rows chained per tap
    always_comb begin
        for (int t = 0; t < `PEC_KERNEL; t++) begin
            sumWord[t] = markReg.frtRow ? rdData[t] : accReg[t];
            for (int r = 0; r < `PEC_KERNEL; r++)
                sumWord[t] = sumWord[t] + rowPsum[r][t];
        end
    end

    assign kernelOut = kernelReg;
    assign actTake   = takeOk;
    assign macStart  = takeOk;
    assign rdEn      = takeOk && heldMark.frtRow;  // Data ready next cycle
    assign wrEn      = runDone && markReg.lstRow;
    assign wrData    = sumWord;
    assign blkEnd    = runDone && markReg.lstBlk;

endmodule

`default_nettype wire

//--- src/psum_buffer.sv
`default_nettype none

`include "pec_params.svh"

// Output side: partial-sum memory and result link
module psum_buffer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      rdEn,
    input  logic                      wrEn,
    input  pec_data_pkg::psumWord_t   wrData,
    input  logic                      blkEnd,
    output pec_data_pkg::psumWord_t   rdData,
    output logic                      resBusy,
    output logic                      resReq,
    input  logic                      resAck,
    output pec_data_pkg::psumAddr_t   resAddr,
    output pec_data_pkg::psumWord_t   resData
);

    pec_data_pkg::psumWord_t mem [`PEC_PSUM_DEPTH];   // One entry per row of a block
    pec_data_pkg::psumAddr_t rdAddr;
    pec_data_pkg::psumAddr_t wrAddr;

    // ========================================================================
    // Memory and row counters
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PEC_PSUM_DEPTH; i++)
                mem[i] <= '0;             // Contents kept across blocks
        end else if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // Counters wrap with the address width, block end restarts at row 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdAddr <= '0;
            wrAddr <= '0;
        end else begin
            if (blkEnd)
                wrAddr <= '0;
            else if (wrEn)
                wrAddr <= wrAddr + 1'b1;
            if (blkEnd)
                rdAddr <= '0;
            else if (rdEn)
                rdAddr <= rdAddr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rdEn)
            rdData <= mem[rdAddr];
        if (wrEn) begin
            resAddr <= wrAddr;            // Copy of each written word
            resData <= wrData;
        end
    end

    // ========================================================================
    // Result link sender
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            resReq <= 1'b0;
        else if (wrEn)
            resReq <= 1'b1;
        else if (resReq && resAck)
            resReq <= 1'b0;
    end

    assign resBusy = resReq | resAck;     // Until receiver drops ack

endmodule

`default_nettype wire

//--- src/pe_cluster.sv
`default_nettype none

`include "pec_params.svh"

// Processing-element cluster top
module pe_cluster (
    input  logic                    clk,
    input  logic                    rst_n,
    // Weight link
    input  logic                    weiReq,
    output logic                    weiAck,
    input  pec_data_pkg::kernel_t   kernel,
    // Activation link from previous element
    input  logic                    actReq,
    output logic                    actAck,
    input  pec_data_pkg::actWord_t  actIn,
    // Forward link to next element
    output logic                    nxtReq,
    input  logic                    nxtAck,
    output pec_data_pkg::actWord_t  nxtAct,
    // Result link
    output logic                    resReq,
    input  logic                    resAck,
    output pec_data_pkg::psumAddr_t resAddr,
    output pec_data_pkg::psumWord_t resData
);

    logic                                      actValid, actTake, fwdBusy;
    pec_data_pkg::actWord_t                    heldAct;
    logic                                      macStart;
    logic [`PEC_KERNEL-1:0]                    rowDone;
    pec_data_pkg::psumWord_t [`PEC_KERNEL-1:0] rowPsum;
    pec_data_pkg::kernel_t                     kernelRun;   // Captured weight set
    logic                                      rdEn, wrEn, blkEnd, resBusy;
    pec_data_pkg::psumWord_t                   wrData, rdData;

    act_stage actStageInst (
        .clk      (clk),
        .rst_n    (rst_n),
        .actReq   (actReq),
        .actAck   (actAck),
        .actIn    (actIn),
        .actValid (actValid),
        .heldAct  (heldAct),
        .actTake  (actTake),
        .fwdBusy  (fwdBusy),
        .nxtReq   (nxtReq),
        .nxtAck   (nxtAck),
        .nxtAct   (nxtAct)
    );

    pec_ctrl pecCtrlInst (
        .clk       (clk),
        .rst_n     (rst_n),
        .weiReq    (weiReq),
        .weiAck    (weiAck),
        .kernelIn  (kernel),
        .kernelOut (kernelRun),
        .actValid  (actValid),
        .heldMark  (heldAct.mark),
        .actTake   (actTake),
        .fwdBusy   (fwdBusy),
        .resBusy   (resBusy),
        .macStart  (macStart),
        .rowDone   (rowDone),
        .rowPsum   (rowPsum),
        .rdData    (rdData),
        .rdEn      (rdEn),
        .wrEn      (wrEn),
        .wrData    (wrData),
        .blkEnd    (blkEnd)
    );

    // One MAC row per kernel row
    for (genvar r = 0; r < `PEC_KERNEL; r++) begin : genRow
        mac_row macRowInst (
            .clk      (clk),
            .rst_n    (rst_n),
            .macStart (macStart),
            .act      (heldAct.act),
            .actFlags (heldAct.flags),
            .weights  (kernelRun[r]),
            .done     (rowDone[r]),
            .rowPsum  (rowPsum[r])
        );
    end

    psum_buffer psumBufferInst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rdEn    (rdEn),
        .wrEn    (wrEn),
        .wrData  (wrData),
        .blkEnd  (blkEnd),
        .rdData  (rdData),
        .resBusy (resBusy),
        .resReq  (resReq),
        .resAck  (resAck),
        .resAddr (resAddr),
        .resData (resData)
    );

endmodule

`default_nettype wire

//--- tests/pe_cluster_asserts.sv
`default_nettype none

`include "pec_params.svh"

// Handshake and control checks bound into pe_cluster
module pe_cluster_asserts (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    weiReq,
    input logic                    weiAck,
    input logic                    actReq,
    input logic                    actAck,
    input logic                    nxtReq,
    input logic                    nxtAck,
    input pec_data_pkg::actWord_t  nxtAct,
    input logic                    resReq,
    input logic                    resAck,
    input pec_data_pkg::psumAddr_t resAddr,
    input pec_data_pkg::psumWord_t resData,
    input logic                    rdEn,
    input logic                    wrEn,
    input logic                    blkEnd,
    input logic                    macStart,
    input logic [`PEC_KERNEL-1:0]  rowDone,
    input pec_ctrl_pkg::pecState_t ctrlState
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned failCount = 0;   // Assertion failures so far

    // ========================================================================
    // Four-phase order with req dropping only while ack is up
    // ========================================================================
    weiOrder: assert property (@(posedge clk) disable iff (!rst_n) $fell(weiReq) |-> weiAck)
        else begin
            failCount++;
            $error("weiReq fell before weiAck");
        end
    actOrder: assert property (@(posedge clk) disable iff (!rst_n) $fell(actReq) |-> actAck)
        else begin
            failCount++;
            $error("actReq fell before actAck");
        end
    nxtOrder: assert property (@(posedge clk) disable iff (!rst_n) $fell(nxtReq) |-> nxtAck)
        else begin
            failCount++;
            $error("nxtReq fell before nxtAck");
        end
    resOrder: assert property (@(posedge clk) disable iff (!rst_n) $fell(resReq) |-> resAck)
        else begin
            failCount++;
            $error("resReq fell before resAck");
        end

    // Outbound data frozen while req is up
    nxtStable: assert property (@(posedge clk) disable iff (!rst_n)
        nxtReq && $past(nxtReq) |-> $stable(nxtAct))
        else begin
            failCount++;
            $error("nxtAct changed under nxtReq");
        end
    resStable: assert property (@(posedge clk) disable iff (!rst_n)
        resReq && $past(resReq) |-> $stable(resAddr) && $stable(resData))
        else begin
            failCount++;
            $error("result changed under resReq");
        end

    // ========================================================================
    // Controller
    // ========================================================================
    // Result register is never touched while its handshake is open
    resIdle: assert property (@(posedge clk) disable iff (!rst_n)
        (rdEn || wrEn || blkEnd) |-> !resReq && !resAck)
        else begin
            failCount++;
            $error("psum access while the result link is busy");
        end
    // Rows drop done on start so RUN never sees the last activation's done
    startState: assert property (@(posedge clk) disable iff (!rst_n)
        macStart |=> ctrlState == pec_ctrl_pkg::RUN && rowDone == '0)
        else begin
            failCount++;
            $error("stale row done after macStart");
        end

endmodule

`default_nettype wire

//--- tests/pe_cluster_tb.sv
`default_nettype none

`include "pec_params.svh"

module pe_cluster_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 4000;   // Five tests near 600 cycles each plus margin

    // One word seen on the result link
    typedef struct packed {
        pec_data_pkg::psumAddr_t addr;
        pec_data_pkg::psumWord_t data;
    } resItem_t;

    logic                    clk;
    logic                    rst_n;
    logic                    weiReq;
    logic                    weiAck;
    pec_data_pkg::kernel_t   kernel;
    logic                    actReq;
    logic                    actAck;
    pec_data_pkg::actWord_t  actIn;
    logic                    nxtReq;
    logic                    nxtAck;
    pec_data_pkg::actWord_t  nxtAct;
    logic                    resReq;
    logic                    resAck;
    pec_data_pkg::psumAddr_t resAddr;
    pec_data_pkg::psumWord_t resData;

    pec_data_pkg::psumWord_t modelMem [`PEC_PSUM_DEPTH];   // Mirror of the psum memory
    resItem_t                expRes [$];
    resItem_t                gotRes [$];
    pec_data_pkg::actWord_t  expFwd [$];
    pec_data_pkg::actWord_t  gotFwd [$];
    int                      fwdStallMax;
    int                      resStallMax;
    int                      cycles;
    string                   testName;

    pe_cluster pe_cluster_inst (.*);

    bind pe_cluster pe_cluster_asserts assertsInst (.*, .ctrlState(pecCtrlInst.state));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (pe_cluster_inst.assertsInst.failCount != 0) begin
                $display("Assertion failure in test %s", testName);
                $display("Something failed");
                $fatal(1, "Assertion failed");
            end else if (cycles >= TIMEOUT_CYCLES) begin
                $display("Run timed out after %0d cycles in test %s", cycles, testName);
                $display("Something failed");
                $fatal(1, "Timeout");
            end
        end
    end

    task automatic checkEq(input string what, input logic [63:0] expVal,
                           input logic [63:0] actVal);
        if (expVal !== actVal) begin
            $display("FAILED %s %s: expected %h, actual %h", testName, what, expVal, actVal);
            $display("Something failed");
            $fatal(1, "Mismatch");
        end
    endtask

    // No capture while the forward copy is still in flight
    initial begin
        logic prevAck;
        logic prevBusy;
        prevAck  = 1'b0;
        prevBusy = 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n && actAck && !prevAck)
                checkEq("capture while forward busy", 64'd0, 64'(prevBusy));
            prevAck  = actAck;
            prevBusy = nxtReq | nxtAck;
        end
    end

    // ========================================================================
    // Link agents
    // ========================================================================
    task automatic sendWeights(input pec_data_pkg::kernel_t k);
        @(posedge clk);
        kernel <= k;
        weiReq <= 1'b1;
        do @(posedge clk); while (!weiAck);
        weiReq <= 1'b0;
        do @(posedge clk); while (weiAck);
    endtask

    task automatic sendAct(input pec_data_pkg::actWord_t w);
        @(posedge clk);
        actIn  <= w;
        actReq <= 1'b1;
        do @(posedge clk); while (!actAck);
        actReq <= 1'b0;
        do @(posedge clk); while (actAck);
    endtask

    task automatic ackForward(input int stallMax);
        int stall;
        stall = int'($urandom_range(stallMax, 0));
        do @(posedge clk); while (!nxtReq);
        gotFwd.push_back(nxtAct);
        repeat (stall) @(posedge clk);
        nxtAck <= 1'b1;
        do @(posedge clk); while (nxtReq);
        nxtAck <= 1'b0;
    endtask

    task automatic ackResult(input int stallMax);
        int       stall;
        resItem_t item;
        stall = int'($urandom_range(stallMax, 0));
        do @(posedge clk); while (!resReq);
        item.addr = resAddr;
        item.data = resData;
        gotRes.push_back(item);
        repeat (stall) @(posedge clk);
        resAck <= 1'b1;
        do @(posedge clk); while (resReq);
        resAck <= 1'b0;
    endtask

    // ========================================================================
    // Stimulus and reference model
    // ========================================================================
    function automatic pec_data_pkg::kernel_t randKernel(input bit dense);
        pec_data_pkg::kernel_t k;
        for (int r = 0; r < `PEC_KERNEL; r++) begin
            for (int t = 0; t < `PEC_KERNEL; t++) begin
                k[r].wei[t] = $urandom;
                k[r].flg[t] = dense ? '1 : pec_data_pkg::flagVec_t'($urandom);
            end
        end
        return k;
    endfunction

    // Values under cleared flags stay random
    function automatic pec_data_pkg::actWord_t randAct(input bit dense);
        pec_data_pkg::actWord_t w;
        w.act   = $urandom;
        w.flags = dense ? '1 : pec_data_pkg::flagVec_t'($urandom);
        w.mark  = '0;
        return w;
    endfunction

    // Adds one activation over all kernel rows and doubly flagged channels
    function automatic pec_data_pkg::psumWord_t addContrib(input pec_data_pkg::psumWord_t base,
                                                           input pec_data_pkg::kernel_t k,
                                                           input pec_data_pkg::actWord_t a);
        pec_data_pkg::psumWord_t s;
        int                      sum;
        s = base;
        for (int t = 0; t < `PEC_KERNEL; t++) begin
            sum = 0;
            for (int r = 0; r < `PEC_KERNEL; r++) begin
                for (int c = 0; c < `PEC_CHANNEL_DEPTH; c++) begin
                    if (a.flags[c] && k[r].flg[t][c])
                        sum += int'($signed(a.act[c])) * int'($signed(k[r].wei[t][c]));
                end
            end
            s[t] = s[t] + pec_data_pkg::psum_t'(sum);   // Wraps at psum width
        end
        return s;
    endfunction

    // New weight set and one block with row r at address r
    task automatic runBlock(input int rows, input int perRow, input bit dense);
        pec_data_pkg::kernel_t   k;
        pec_data_pkg::actWord_t  w;
        pec_data_pkg::psumWord_t word;
        resItem_t                item;
        k = randKernel(dense);
        sendWeights(k);
        for (int r = 0; r < rows; r++) begin
            word = modelMem[r];                  // Read at first of row
            for (int i = 0; i < perRow; i++) begin
                w             = randAct(dense);
                w.mark.frtRow = (i == 0);
                w.mark.lstRow = (i == perRow - 1);
                w.mark.lstBlk = (i == perRow - 1) && (r == rows - 1);
                word          = addContrib(word, k, w);
                expFwd.push_back(w);
                sendAct(w);
            end
            modelMem[r] = word;
            item.addr   = pec_data_pkg::psumAddr_t'(r);
            item.data   = word;
            expRes.push_back(item);
        end
    endtask

    task automatic compareResults();
        while (gotRes.size() < expRes.size() || gotFwd.size() < expFwd.size())
            @(posedge clk);
        while (resReq || resAck || nxtReq || nxtAck)
            @(posedge clk);                      // Any duplicate shows up by now
        checkEq("result count", 64'(expRes.size()), 64'(gotRes.size()));
        checkEq("forward count", 64'(expFwd.size()), 64'(gotFwd.size()));
        foreach (expRes[i]) begin
            checkEq($sformatf("result %0d addr", i), 64'(expRes[i].addr), 64'(gotRes[i].addr));
            checkEq($sformatf("result %0d data", i), 64'(expRes[i].data), 64'(gotRes[i].data));
        end
        foreach (expFwd[i])
            checkEq($sformatf("forward %0d", i), 64'(expFwd[i]), 64'(gotFwd[i]));
        expRes.delete();
        gotRes.delete();
        expFwd.delete();
        gotFwd.delete();
    endtask

    // ========================================================================
    // Tests
    // ========================================================================
    task automatic denseRow();
        testName = "dense_row";
        runBlock(1, 2, 1'b1);
        compareResults();
    endtask

    task automatic sparseChannels();
        testName = "sparsity";
        runBlock(2, 3, 1'b0);
        compareResults();
    endtask

    task automatic blockAccumulation();
        testName = "block_accumulation";
        runBlock(3, 2, 1'b0);
        runBlock(3, 2, 1'b0);                    // Builds on the first block
        compareResults();
    endtask

    task automatic forwardOrder();
        testName = "forwarding";
        runBlock(2, 4, 1'b0);
        compareResults();
    endtask

    task automatic backPressure();
        testName    = "back_pressure";
        fwdStallMax = 9;
        resStallMax = 12;
        runBlock(3, 3, 1'b0);
        runBlock(2, 2, 1'b1);
        compareResults();
    endtask

    initial begin
        rst_n       = 1'b0;
        weiReq      = 1'b0;
        kernel      = '0;
        actReq      = 1'b0;
        actIn       = '0;
        nxtAck      = 1'b0;
        resAck      = 1'b0;
        fwdStallMax = 0;
        resStallMax = 0;
        testName    = "reset";
        foreach (modelMem[i])
            modelMem[i] = '0;                    // Memory cleared by reset
        void'($urandom(32'hcbd2));
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        fork
            forever ackForward(fwdStallMax);
            forever ackResult(resStallMax);
        join_none
        denseRow();
        sparseChannels();
        blockAccumulation();
        forwardOrder();
        backPressure();
        if (pe_cluster_inst.assertsInst.failCount == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("%0d assertion failures during the run",
                     pe_cluster_inst.assertsInst.failCount);
            $display("Something failed");
            $fatal(1, "Assertions failed");
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
src/pec_ctrl_pkg.sv
src/pec_data_pkg.sv
src/act_stage.sv
src/mac_row.sv
src/pec_ctrl.sv
src/psum_buffer.sv
src/pe_cluster.sv
tests/pe_cluster_asserts.sv
tests/pe_cluster_tb.sv

//--- Makefile
TOP = pe_cluster_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		-f sources.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee run.log
	grep -q "Everything OK" run.log

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/100ps \
		-f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log
